// ==== clint/clint_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module clint_timer import bus_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	lite_rd_if.subordinate bus
);

	logic [2*DATA_W-1:0] mtime;
	logic [DATA_W-1:0]   rd_word;
	logic                ar_fire;
	logic                r_fire;

	assign ar_fire = bus.arvalid && bus.arready;
	assign r_fire  = bus.rvalid && bus.rready;

	// one response in flight at a time
	assign bus.arready = !bus.rvalid;
	assign bus.rresp   = RESP_OKAY;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + 1'b1; // free running, one tick per cycle
		end
	end

	always_comb begin
		case (bus.araddr)
			MTIME_LO_ADDR: rd_word = mtime[DATA_W-1:0];
			MTIME_HI_ADDR: rd_word = mtime[2*DATA_W-1:DATA_W];
			default:       rd_word = '0; // rest of the window reads as zero
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bus.rvalid <= 1'b0;
		end else if (ar_fire) begin
			bus.rvalid <= 1'b1;
		end else if (r_fire) begin
			bus.rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			bus.rdata <= rd_word; // sampled at the address cycle
		end
	end

endmodule

`default_nettype wire

// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int STRB_W     = DATA_W / 8;
	localparam int CNT_W      = 32;
	localparam int BEAT_CNT_W = 3;

	// external AXI4 field widths
	localparam int AXI_ID_W   = 4;
	localparam int AXI_LEN_W  = 8;
	localparam int IFU_LEN_W  = 4;
	localparam int SIZE_W     = 3;
	localparam int BURST_W    = 2;

	// CLINT window and mtime registers
	localparam logic [ADDR_W-1:0] CLINT_BASE    = 32'h0200_0000;
	localparam logic [ADDR_W-1:0] CLINT_LIMIT   = 32'h0201_0000;
	localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'h0200_bff8;
	localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = 32'h0200_bffc;

	localparam logic [SIZE_W-1:0]   IFU_ARSIZE  = 3'b010; // 4 bytes per beat
	localparam logic [AXI_ID_W-1:0] AXI_ID      = '0;     // only id in use
	localparam logic [BURST_W-1:0]  BURST_FIXED = 2'b00;

	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== common/lite_rd_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface lite_rd_if import bus_pkg::*; ();

	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;

	logic [DATA_W-1:0] rdata;
	resp_t             rresp;
	logic              rvalid;
	logic              rready;

	modport manager (
		output araddr,
		output arvalid,
		input  arready,
		input  rdata,
		input  rresp,
		input  rvalid,
		output rready
	);

	modport subordinate (
		input  araddr,
		input  arvalid,
		output arready,
		output rdata,
		output rresp,
		output rvalid,
		input  rready
	);

endinterface

`default_nettype wire

// ==== design/access_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module access_counter import bus_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  logic             lsu_reading,
	input  logic             lsu_writing,
	output logic [CNT_W-1:0] lsu_read_cycles,
	output logic [CNT_W-1:0] lsu_write_cycles
);

	always_ff @(posedge clock) begin
		if (reset) begin
			lsu_read_cycles <= '0;
		end else if (lsu_reading && !(&lsu_read_cycles)) begin
			lsu_read_cycles <= lsu_read_cycles + 1'b1; // stops at all ones
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lsu_write_cycles <= '0;
		end else if (lsu_writing && !(&lsu_write_cycles)) begin
			lsu_write_cycles <= lsu_write_cycles + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/mem_subsys_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top import bus_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,

	input  logic [ADDR_W-1:0]    ifu_araddr,
	input  logic                 ifu_arvalid,
	output logic                 ifu_arready,
	input  logic [BURST_W-1:0]   ifu_arburst,
	input  logic [IFU_LEN_W-1:0] ifu_arlen,
	output logic [DATA_W-1:0]    ifu_rdata,
	output resp_t                ifu_rresp,
	output logic                 ifu_rvalid,
	input  logic                 ifu_rready,

	input  logic [ADDR_W-1:0]    lsu_araddr,
	input  logic                 lsu_arvalid,
	input  logic [SIZE_W-1:0]    lsu_arsize,
	output logic                 lsu_arready,
	output logic [DATA_W-1:0]    lsu_rdata,
	output resp_t                lsu_rresp,
	output logic                 lsu_rvalid,
	input  logic                 lsu_rready,

	input  logic [ADDR_W-1:0]    lsu_awaddr,
	input  logic                 lsu_awvalid,
	input  logic [SIZE_W-1:0]    lsu_awsize,
	output logic                 lsu_awready,
	input  logic [DATA_W-1:0]    lsu_wdata,
	input  logic [STRB_W-1:0]    lsu_wstrb,
	input  logic                 lsu_wvalid,
	output logic                 lsu_wready,
	output resp_t                lsu_bresp,
	output logic                 lsu_bvalid,
	input  logic                 lsu_bready,

	input  logic                 io_master_awready,
	output logic                 io_master_awvalid,
	output logic [ADDR_W-1:0]    io_master_awaddr,
	output logic [AXI_ID_W-1:0]  io_master_awid,
	output logic [AXI_LEN_W-1:0] io_master_awlen,
	output logic [SIZE_W-1:0]    io_master_awsize,
	output logic [BURST_W-1:0]   io_master_awburst,
	input  logic                 io_master_wready,
	output logic                 io_master_wvalid,
	output logic [DATA_W-1:0]    io_master_wdata,
	output logic [STRB_W-1:0]    io_master_wstrb,
	output logic                 io_master_wlast,
	output logic                 io_master_bready,
	input  logic                 io_master_bvalid,
	input  resp_t                io_master_bresp,
	input  logic [AXI_ID_W-1:0]  io_master_bid,
	input  logic                 io_master_arready,
	output logic                 io_master_arvalid,
	output logic [ADDR_W-1:0]    io_master_araddr,
	output logic [AXI_ID_W-1:0]  io_master_arid,
	output logic [AXI_LEN_W-1:0] io_master_arlen,
	output logic [SIZE_W-1:0]    io_master_arsize,
	output logic [BURST_W-1:0]   io_master_arburst,
	output logic                 io_master_rready,
	input  logic                 io_master_rvalid,
	input  resp_t                io_master_rresp,
	input  logic [DATA_W-1:0]    io_master_rdata,
	input  logic                 io_master_rlast,
	input  logic [AXI_ID_W-1:0]  io_master_rid,

	output logic [CNT_W-1:0]     lsu_read_cycles,
	output logic [CNT_W-1:0]     lsu_write_cycles
);

	logic lsu_reading;
	logic lsu_writing;

	lite_rd_if clint_rd ();

	xbar_read_arbiter u_read_arbiter (
		.clock, .reset,
		.ifu_araddr, .ifu_arvalid, .ifu_arready, .ifu_arburst, .ifu_arlen,
		.ifu_rdata, .ifu_rresp, .ifu_rvalid, .ifu_rready,
		.lsu_araddr, .lsu_arvalid, .lsu_arsize, .lsu_arready,
		.lsu_rdata, .lsu_rresp, .lsu_rvalid, .lsu_rready,
		.io_master_arready, .io_master_arvalid, .io_master_araddr, .io_master_arid,
		.io_master_arlen, .io_master_arsize, .io_master_arburst,
		.io_master_rready, .io_master_rvalid, .io_master_rresp, .io_master_rdata,
		.io_master_rlast, .io_master_rid,
		.clint       (clint_rd.manager),
		.lsu_reading
	);

	xbar_write_channel u_write_channel (
		.clock, .reset,
		.lsu_awaddr, .lsu_awvalid, .lsu_awsize, .lsu_awready,
		.lsu_wdata, .lsu_wstrb, .lsu_wvalid, .lsu_wready,
		.lsu_bresp, .lsu_bvalid, .lsu_bready,
		.io_master_awready, .io_master_awvalid, .io_master_awaddr, .io_master_awid,
		.io_master_awlen, .io_master_awsize, .io_master_awburst,
		.io_master_wready, .io_master_wvalid, .io_master_wdata, .io_master_wstrb,
		.io_master_wlast,
		.io_master_bready, .io_master_bvalid, .io_master_bresp, .io_master_bid,
		.lsu_writing
	);

	clint_timer u_clint (
		.clock,
		.reset,
		.bus (clint_rd.subordinate)
	);

	access_counter u_access_counter (
		.clock, .reset,
		.lsu_reading, .lsu_writing,
		.lsu_read_cycles, .lsu_write_cycles
	);

endmodule

`default_nettype wire

// ==== files.f ====
common/bus_pkg.sv
common/lite_rd_if.sv
xbar/xbar_read_arbiter.sv
xbar/xbar_write_channel.sv
clint/clint_timer.sv
design/access_counter.sv
design/mem_subsys_top.sv
verif/soc_mem_model.sv
verif/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module tb_mem_subsys -f files.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "^all tests passed$" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see sim.log"
exit 1

// ==== verif/soc_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_mem_model import bus_pkg::*; #(
	parameter logic [31:0] SEED = 32'h6605_af3a
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 stall_en,
	input  logic                 io_master_arvalid, io_master_rready,
	input  logic [ADDR_W-1:0]    io_master_araddr,
	input  logic [AXI_LEN_W-1:0] io_master_arlen,
	input  logic [BURST_W-1:0]   io_master_arburst,
	output logic                 io_master_arready, io_master_rvalid, io_master_rlast,
	output logic [DATA_W-1:0]    io_master_rdata,
	output resp_t                io_master_rresp,
	output logic [AXI_ID_W-1:0]  io_master_rid,
	input  logic                 io_master_awvalid, io_master_wvalid, io_master_bready,
	output logic                 io_master_awready, io_master_wready, io_master_bvalid,
	output resp_t                io_master_bresp,
	output logic [AXI_ID_W-1:0]  io_master_bid
);

	integer               seed;
	logic                 in_reset;
	logic                 rd_active, aw_got, w_got;
	logic [ADDR_W-1:0]    rd_addr;
	logic [AXI_LEN_W-1:0] rd_left;
	logic [BURST_W-1:0]   rd_burst;
	logic                 ar_fire, r_fire, aw_fire, w_fire, b_fire;

	// with stalls on, a ready or valid stays low about a third of the cycles
	function automatic logic ready_roll();
		return !stall_en || (($random(seed) % 3) != 0);
	endfunction

	initial begin
		seed = SEED;
		rd_active = 1'b0;
		aw_got = 1'b0;
		w_got = 1'b0;
		rd_addr = '0;
		rd_left = '0;
		rd_burst = '0;
		io_master_arready = 1'b0;
		io_master_rvalid = 1'b0;
		io_master_rlast = 1'b0;
		io_master_rdata = '0;
		io_master_rresp = RESP_OKAY;
		io_master_rid = '0;
		io_master_awready = 1'b0;
		io_master_wready = 1'b0;
		io_master_bvalid = 1'b0;
		io_master_bresp = RESP_OKAY;
		io_master_bid = '0;
		forever begin
			@(negedge clock); // inputs are stable here, transfers land on the next edge
			in_reset = reset;
			ar_fire = io_master_arvalid && io_master_arready;
			r_fire = io_master_rvalid && io_master_rready;
			aw_fire = io_master_awvalid && io_master_awready;
			w_fire = io_master_wvalid && io_master_wready;
			b_fire = io_master_bvalid && io_master_bready;
			@(posedge clock);
			#1;
			if (in_reset) begin
				rd_active = 1'b0;
				aw_got = 1'b0;
				w_got = 1'b0;
				io_master_rvalid = 1'b0;
				io_master_bvalid = 1'b0;
			end else begin
				if (ar_fire) begin
					rd_active = 1'b1;
					rd_addr = io_master_araddr;
					rd_left = io_master_arlen;
					rd_burst = io_master_arburst;
				end else if (r_fire) begin
					if (rd_left == '0) begin
						rd_active = 1'b0;
					end else begin
						rd_left = rd_left - 1'b1;
						if (rd_burst == 2'b01) begin
							rd_addr = rd_addr + 32'd4; // incr burst
						end
					end
				end
				if (b_fire) begin
					aw_got = 1'b0;
					w_got = 1'b0;
				end else begin
					aw_got = aw_got || aw_fire;
					w_got = w_got || w_fire;
				end
				io_master_rvalid = rd_active && ((io_master_rvalid && !r_fire) || ready_roll());
				io_master_bvalid = aw_got && w_got && (io_master_bvalid || ready_roll());
			end
			io_master_rdata = rd_addr ^ 32'ha5a5_0000;
			io_master_rlast = (rd_left == '0);
			io_master_arready = !rd_active && ready_roll();
			io_master_awready = !aw_got && ready_roll();
			io_master_wready = !w_got && ready_roll();
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys import bus_pkg::*; ();

	localparam int          N_TESTS  = 6;
	localparam logic [31:0] SEED     = 32'h6605_af3a;
	localparam logic [31:0] PATTERN  = 32'ha5a5_0000;
	localparam logic [31:0] SOC_BASE = 32'h8000_0000;

	logic   clock, reset, stall_en, ifu_busy, clint_phase;
	integer seed, errors, n_reads, n_writes;
	logic [31:0] rd_data, lo_first, lo_second, addr, rnd, rd_cnt, wr_cnt;

	logic [ADDR_W-1:0]    ifu_araddr, lsu_araddr, lsu_awaddr;
	logic                 ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	logic [BURST_W-1:0]   ifu_arburst;
	logic [IFU_LEN_W-1:0] ifu_arlen;
	logic [DATA_W-1:0]    ifu_rdata, lsu_rdata, lsu_wdata;
	resp_t                ifu_rresp, lsu_rresp, lsu_bresp;
	logic                 lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	logic [SIZE_W-1:0]    lsu_arsize, lsu_awsize;
	logic                 lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready;
	logic                 lsu_bvalid, lsu_bready;
	logic [STRB_W-1:0]    lsu_wstrb, io_master_wstrb;
	logic                 io_master_awready, io_master_awvalid, io_master_wready;
	logic                 io_master_wvalid, io_master_wlast, io_master_bready, io_master_bvalid;
	logic                 io_master_arready, io_master_arvalid, io_master_rready;
	logic                 io_master_rvalid, io_master_rlast;
	logic [ADDR_W-1:0]    io_master_awaddr, io_master_araddr;
	logic [AXI_ID_W-1:0]  io_master_awid, io_master_bid, io_master_arid, io_master_rid;
	logic [AXI_LEN_W-1:0] io_master_awlen, io_master_arlen;
	logic [SIZE_W-1:0]    io_master_awsize, io_master_arsize;
	logic [BURST_W-1:0]   io_master_awburst, io_master_arburst;
	logic [DATA_W-1:0]    io_master_wdata, io_master_rdata;
	resp_t                io_master_bresp, io_master_rresp;
	logic [CNT_W-1:0]     lsu_read_cycles, lsu_write_cycles;

	mem_subsys_top u_dut (.*);

	soc_mem_model #(.SEED(SEED)) u_soc (.*);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	task automatic check_equal(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	function automatic logic ready_pick();
		return !stall_en || (($random(seed) % 3) != 0);
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	// all tasks start and end 1 ns after a rising edge, outputs are sampled at the falling edge
	task automatic ifu_burst(input logic [31:0] start, input logic [3:0] len,
		input logic [1:0] burst);
		int          beats;
		logic [31:0] beat_addr;
		beats = 0;
		beat_addr = start;
		ifu_busy = 1'b1;
		ifu_araddr = start;
		ifu_arlen = len;
		ifu_arburst = burst;
		ifu_arvalid = 1'b1;
		@(negedge clock);
		check_equal("ifu arready before grant", 0, ifu_arready); // earlier grant must be gone
		while (!ifu_arready) @(negedge clock);
		check_equal("ifu arlen", {28'b0, len}, io_master_arlen);
		check_equal("ifu arsize", 3'b010, io_master_arsize);
		check_equal("ifu arid", 0, io_master_arid);
		@(posedge clock);
		#1;
		ifu_arvalid = 1'b0;
		while (beats <= len) begin
			ifu_rready = ready_pick();
			@(negedge clock);
			if (ifu_rvalid && ifu_rready) begin
				check_equal("ifu beat data", beat_addr ^ PATTERN, ifu_rdata);
				check_equal("ifu rresp", RESP_OKAY, ifu_rresp);
				beats++;
				if (burst == 2'b01) beat_addr = beat_addr + 32'd4;
			end else begin
				check_equal("ifu arready in burst", 0, ifu_arready); // no second request yet
			end
			@(posedge clock);
			#1;
		end
		ifu_rready = 1'b0;
		ifu_busy = 1'b0;
	endtask

	task automatic lsu_read(input logic [31:0] where, output logic [31:0] data);
		n_reads++;
		lsu_araddr = where; // held until the response, it steers the r channel
		lsu_arsize = 3'b010;
		lsu_arvalid = 1'b1;
		@(negedge clock);
		while (!lsu_arready) @(negedge clock);
		@(posedge clock);
		#1;
		lsu_arvalid = 1'b0;
		lsu_rready = ready_pick();
		@(negedge clock);
		while (!(lsu_rvalid && lsu_rready)) begin
			@(posedge clock);
			#1;
			lsu_rready = ready_pick();
			@(negedge clock);
		end
		data = lsu_rdata;
		check_equal("lsu rresp", RESP_OKAY, lsu_rresp);
		@(posedge clock);
		#1;
		lsu_rready = 1'b0;
	endtask

	task automatic lsu_write(input logic [31:0] where, input logic [31:0] data,
		input logic [3:0] strb);
		logic aw_done, w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		n_writes++;
		lsu_awaddr = where;
		lsu_awsize = 3'b010;
		lsu_awvalid = 1'b1;
		lsu_wdata = data;
		lsu_wstrb = strb;
		lsu_wvalid = 1'b1;
		while (!(aw_done && w_done)) begin
			@(negedge clock);
			if (lsu_awvalid && lsu_awready) begin
				check_equal("write awaddr", where, io_master_awaddr);
				check_equal("write awlen", 0, io_master_awlen);
				check_equal("write awid", 0, io_master_awid);
				check_equal("write awburst", 0, io_master_awburst);
				check_equal("write awsize", 3'b010, io_master_awsize);
				aw_done = 1'b1;
			end
			if (lsu_wvalid && lsu_wready) begin
				check_equal("write wdata", data, io_master_wdata);
				check_equal("write wstrb", {28'b0, strb}, io_master_wstrb);
				check_equal("write wlast", 1, io_master_wlast);
				w_done = 1'b1;
			end
			@(posedge clock);
			#1;
			lsu_awvalid = lsu_awvalid && !aw_done;
			lsu_wvalid = lsu_wvalid && !w_done;
		end
		lsu_bready = ready_pick();
		@(negedge clock);
		while (!(lsu_bvalid && lsu_bready)) begin
			@(posedge clock);
			#1;
			lsu_bready = ready_pick();
			@(negedge clock);
		end
		check_equal("write bresp", io_master_bresp, lsu_bresp);
		@(posedge clock);
		#1;
		lsu_bready = 1'b0;
	endtask

	always @(negedge clock) begin
		if (ifu_busy) check_equal("priority lsu_arready", 0, lsu_arready);
		if (clint_phase) check_equal("clint io_master_arvalid", 0, io_master_arvalid);
		check_equal("write bvalid", io_master_bvalid, lsu_bvalid);
	end

	initial begin
		repeat (N_TESTS * 2000) @(posedge clock);
		$display("watchdog expired after %0d cycles, a handshake never completed", N_TESTS * 2000);
		$display("tests failed");
		$finish;
	end

	initial begin
		seed = SEED;
		errors = 0;
		n_reads = 0;
		n_writes = 0;
		ifu_busy = 1'b0;
		clint_phase = 1'b0;
		stall_en = 1'b0;
		reset = 1'b1;
		ifu_araddr = '0;
		ifu_arvalid = 1'b0;
		ifu_arburst = 2'b01;
		ifu_arlen = '0;
		ifu_rready = 1'b0;
		lsu_araddr = '0;
		lsu_arvalid = 1'b0;
		lsu_arsize = 3'b010;
		lsu_rready = 1'b0;
		lsu_awaddr = '0;
		lsu_awvalid = 1'b0;
		lsu_awsize = 3'b010;
		lsu_wdata = '0;
		lsu_wstrb = '0;
		lsu_wvalid = 1'b0;
		lsu_bready = 1'b0;
		repeat (9) @(posedge clock);
		@(negedge clock);
		check_equal("reset io_master_arvalid", 0, io_master_arvalid);
		check_equal("reset ifu_rvalid", 0, ifu_rvalid);
		check_equal("reset lsu_rvalid", 0, lsu_rvalid);
		check_equal("reset read cycles", 0, lsu_read_cycles);
		check_equal("reset write cycles", 0, lsu_write_cycles);
		@(posedge clock);
		#1;
		reset = 1'b0;
		idle_cycles(3);

		// IFU bursts back to back, the second only after the first has ended
		ifu_burst(SOC_BASE + 32'h100, 4'd3, 2'b01);
		ifu_burst(SOC_BASE + 32'h180, 4'd7, 2'b01);
		ifu_burst(SOC_BASE + 32'h1c0, 4'd2, 2'b00);
		repeat (3) begin
			@(negedge clock);
			check_equal("ifu beat after burst", 0, ifu_rvalid);
		end
		idle_cycles(1);

		fork
			ifu_burst(SOC_BASE + 32'h200, 4'd3, 2'b01);
			lsu_read(SOC_BASE + 32'h400, rd_data);
		join
		check_equal("priority lsu data", (SOC_BASE + 32'h400) ^ PATTERN, rd_data);

		clint_phase = 1'b1;
		lsu_read(MTIME_LO_ADDR, lo_first);
		lsu_read(MTIME_HI_ADDR, rd_data);
		check_equal("mtime high word", 0, rd_data);
		lsu_read(MTIME_LO_ADDR, lo_second);
		assert ((lo_first != 0) && (lo_second > lo_first)) else begin
			errors++;
			$display("mtime low word did not advance between reads: %h then %h",
				lo_first, lo_second);
		end
		lsu_read(CLINT_BASE + 32'h40, rd_data);
		check_equal("clint other word", 0, rd_data);
		clint_phase = 1'b0;

		lsu_write(SOC_BASE + 32'h800, 32'h1234_5678, 4'b1111);
		lsu_write(SOC_BASE + 32'h804, 32'h0bad_f00d, 4'b0110);

		stall_en = 1'b1; // model and testbench both drop readies at random
		for (int i = 0; i < 15; i++) begin
			rnd = $random(seed);
			addr = SOC_BASE | (rnd & 32'h00ff_fffc);
			rnd = $random(seed);
			case (i % 3)
				0: ifu_burst(addr, {1'b0, rnd[2:0]}, rnd[3] ? 2'b01 : 2'b00);
				1: begin
					lsu_read(addr, rd_data);
					check_equal("stalled lsu data", addr ^ PATTERN, rd_data);
				end
				default: lsu_write(addr, rnd, rnd[7:4] | 4'b0001);
			endcase
		end
		stall_en = 1'b0;

		idle_cycles(5);
		@(negedge clock);
		rd_cnt = lsu_read_cycles;
		wr_cnt = lsu_write_cycles;
		assert ((rd_cnt >= n_reads) && (wr_cnt >= n_writes)) else begin
			errors++;
			$display("busy counters too low: reads %0d in %0d cycles, writes %0d in %0d cycles",
				n_reads, rd_cnt, n_writes, wr_cnt);
		end
		repeat (20) @(negedge clock);
		check_equal("idle read cycles", rd_cnt, lsu_read_cycles);
		check_equal("idle write cycles", wr_cnt, lsu_write_cycles);

		$display("error count: %0d", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== xbar/xbar_read_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module xbar_read_arbiter import bus_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,

	input  logic [ADDR_W-1:0]    ifu_araddr,
	input  logic                 ifu_arvalid,
	output logic                 ifu_arready,
	input  logic [BURST_W-1:0]   ifu_arburst,
	input  logic [IFU_LEN_W-1:0] ifu_arlen,
	output logic [DATA_W-1:0]    ifu_rdata,
	output resp_t                ifu_rresp,
	output logic                 ifu_rvalid,
	input  logic                 ifu_rready,

	input  logic [ADDR_W-1:0]    lsu_araddr,
	input  logic                 lsu_arvalid,
	input  logic [SIZE_W-1:0]    lsu_arsize,
	output logic                 lsu_arready,
	output logic [DATA_W-1:0]    lsu_rdata,
	output resp_t                lsu_rresp,
	output logic                 lsu_rvalid,
	input  logic                 lsu_rready,

	input  logic                 io_master_arready,
	output logic                 io_master_arvalid,
	output logic [ADDR_W-1:0]    io_master_araddr,
	output logic [AXI_ID_W-1:0]  io_master_arid,
	output logic [AXI_LEN_W-1:0] io_master_arlen,
	output logic [SIZE_W-1:0]    io_master_arsize,
	output logic [BURST_W-1:0]   io_master_arburst,
	output logic                 io_master_rready,
	input  logic                 io_master_rvalid,
	input  resp_t                io_master_rresp,
	input  logic [DATA_W-1:0]    io_master_rdata,
	input  logic                 io_master_rlast,
	input  logic [AXI_ID_W-1:0]  io_master_rid,

	lite_rd_if.manager           clint,
	output logic                 lsu_reading
);

	logic                  ifu_reading;
	logic [BEAT_CNT_W-1:0] beat_cnt;
	logic                  clint_hit;
	logic                  soc_rvalid;
	logic                  soc_ar_fire;
	logic                  soc_r_fire;
	logic                  ifu_done;
	logic                  lsu_done;

	assign clint_hit   = (lsu_araddr >= CLINT_BASE) && (lsu_araddr < CLINT_LIMIT);
	assign soc_rvalid  = io_master_rvalid && (io_master_rid == AXI_ID);
	assign soc_ar_fire = io_master_arvalid && io_master_arready;
	assign soc_r_fire  = soc_rvalid && io_master_rready;

	// counter at zero marks the last beat, rlast closes it as well
	assign ifu_done = ifu_rvalid && ifu_rready && ((beat_cnt == '0) || io_master_rlast);
	assign lsu_done = lsu_rvalid && lsu_rready;

	always_ff @(posedge clock) begin
		if (reset) begin
			ifu_reading <= 1'b0;
			lsu_reading <= 1'b0;
		end else begin
			ifu_reading <= (!ifu_reading && !lsu_reading && ifu_arvalid)
				|| (ifu_reading && !ifu_done);
			lsu_reading <= (!ifu_reading && !lsu_reading && !ifu_arvalid && lsu_arvalid)
				|| (lsu_reading && !lsu_done); // ifu wins a tie
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			beat_cnt <= '0;
		end else if (soc_r_fire) begin
			beat_cnt <= beat_cnt - 1'b1;
		end else if (soc_ar_fire) begin
			beat_cnt <= io_master_arlen[BEAT_CNT_W-1:0];
		end
	end

	assign io_master_arid = AXI_ID;

	always_comb begin
		io_master_arvalid = 1'b0;
		io_master_araddr  = '0;
		io_master_arlen   = '0;
		io_master_arsize  = '0;
		io_master_arburst = BURST_FIXED;
		io_master_rready  = 1'b0;
		clint.arvalid     = 1'b0;
		clint.araddr      = '0;
		clint.rready      = 1'b0;
		ifu_arready       = 1'b0;
		ifu_rvalid        = 1'b0;
		ifu_rdata         = '0;
		ifu_rresp         = RESP_OKAY;
		lsu_arready       = 1'b0;
		lsu_rvalid        = 1'b0;
		lsu_rdata         = '0;
		lsu_rresp         = RESP_OKAY;
		if (ifu_reading) begin
			io_master_arvalid = ifu_arvalid;
			io_master_araddr  = ifu_araddr;
			io_master_arlen   = {{(AXI_LEN_W - IFU_LEN_W){1'b0}}, ifu_arlen};
			io_master_arsize  = IFU_ARSIZE;
			io_master_arburst = ifu_arburst;
			io_master_rready  = ifu_rready;
			ifu_arready       = io_master_arready;
			ifu_rvalid        = soc_rvalid;
			ifu_rdata         = io_master_rdata;
			ifu_rresp         = io_master_rresp;
		end else if (lsu_reading && clint_hit) begin
			clint.arvalid = lsu_arvalid;
			clint.araddr  = lsu_araddr;
			clint.rready  = lsu_rready;
			lsu_arready   = clint.arready;
			lsu_rvalid    = clint.rvalid;
			lsu_rdata     = clint.rdata;
			lsu_rresp     = clint.rresp;
		end else if (lsu_reading) begin
			io_master_arvalid = lsu_arvalid; // single beat, len 0
			io_master_araddr  = lsu_araddr;
			io_master_arsize  = lsu_arsize;
			io_master_rready  = lsu_rready;
			lsu_arready       = io_master_arready;
			lsu_rvalid        = soc_rvalid;
			lsu_rdata         = io_master_rdata;
			lsu_rresp         = io_master_rresp;
		end
	end

endmodule

`default_nettype wire

// ==== xbar/xbar_write_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

module xbar_write_channel import bus_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,

	input  logic [ADDR_W-1:0]    lsu_awaddr,
	input  logic                 lsu_awvalid,
	input  logic [SIZE_W-1:0]    lsu_awsize,
	output logic                 lsu_awready,
	input  logic [DATA_W-1:0]    lsu_wdata,
	input  logic [STRB_W-1:0]    lsu_wstrb,
	input  logic                 lsu_wvalid,
	output logic                 lsu_wready,
	output resp_t                lsu_bresp,
	output logic                 lsu_bvalid,
	input  logic                 lsu_bready,

	input  logic                 io_master_awready,
	output logic                 io_master_awvalid,
	output logic [ADDR_W-1:0]    io_master_awaddr,
	output logic [AXI_ID_W-1:0]  io_master_awid,
	output logic [AXI_LEN_W-1:0] io_master_awlen,
	output logic [SIZE_W-1:0]    io_master_awsize,
	output logic [BURST_W-1:0]   io_master_awburst,
	input  logic                 io_master_wready,
	output logic                 io_master_wvalid,
	output logic [DATA_W-1:0]    io_master_wdata,
	output logic [STRB_W-1:0]    io_master_wstrb,
	output logic                 io_master_wlast,
	output logic                 io_master_bready,
	input  logic                 io_master_bvalid,
	input  resp_t                io_master_bresp,
	input  logic [AXI_ID_W-1:0]  io_master_bid,

	output logic                 lsu_writing
);

	assign lsu_awready       = io_master_awready;
	assign io_master_awvalid = lsu_awvalid;
	assign io_master_awaddr  = lsu_awaddr;
	assign io_master_awid    = AXI_ID;
	assign io_master_awlen   = '0; // every write is one beat
	assign io_master_awsize  = lsu_awsize;
	assign io_master_awburst = BURST_FIXED;

	assign lsu_wready        = io_master_wready;
	assign io_master_wvalid  = lsu_wvalid;
	assign io_master_wdata   = lsu_wdata;
	assign io_master_wstrb   = lsu_wstrb;
	assign io_master_wlast   = lsu_wvalid;

	assign io_master_bready  = lsu_bready;
	assign lsu_bvalid        = io_master_bvalid && (io_master_bid == AXI_ID);
	assign lsu_bresp         = io_master_bresp;

	always_ff @(posedge clock) begin
		if (reset) begin
			lsu_writing <= 1'b0;
		end else if (lsu_awvalid) begin
			lsu_writing <= 1'b1;
		end else if (lsu_bvalid && lsu_bready) begin
			lsu_writing <= 1'b0; // response taken, write done
		end
	end

endmodule

`default_nettype wire
